/* sim.f */
soc_pkg.sv
axi_xbar.sv
sram_slave.sv
rtc_slave.sv
soc_top.sv
tb_soc_top.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_soc_top -f sim.f -o Vtb_soc_top

run: compile
	./obj_dir/Vtb_soc_top | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" sim.log || (echo "simulation ended early"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

/* tb_soc_top.sv */
module tb_soc_top;
	timeunit 1ns;
	timeprecision 100ps;
	import soc_pkg::*;

	// all tests together take about 250 cycles, so this leaves a wide margin
	localparam int CYCLE_LIMIT = 2000;
	localparam int SRAM_WORDS = 256;
	localparam logic [ADDR_W-1:0] UNMAPPED = 32'h4000_0000;

	logic              clk;
	logic              rst;
	logic [ADDR_W-1:0] araddr;
	logic              arvalid;
	logic              arready;
	logic [DATA_W-1:0] rdata;
	logic [RESP_W-1:0] rresp;
	logic              rvalid;
	logic              rready;
	logic [ADDR_W-1:0] awaddr;
	logic              awvalid;
	logic              awready;
	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;
	logic              wvalid;
	logic              wready;
	logic [RESP_W-1:0] bresp;
	logic              bvalid;
	logic              bready;

	int seed;
	int cycles;
	// expected sram contents, keyed by byte address
	logic [DATA_W-1:0] model [logic [ADDR_W-1:0]];

	soc_top #(
		.SRAM_WORDS(SRAM_WORDS),
		.RTC_DIV(4)
	) soc_top_inst (
		.clk(clk), .rst(rst),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the bus hung, no response within %0d cycles", CYCLE_LIMIT);
		$display("ERRORS FOUND");
		$fatal(1, "run aborted on timeout");
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1, "value mismatch");
		end
	endtask

	// byte merge of a write into the expected contents
	function automatic void note_write(input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] word;
		int b;
		word = model.exists(addr) ? model[addr] : '0;
		for (b = 0; b < STRB_W; b++) begin
			if (strb[b])
				word[8*b +: 8] = data[8*b +: 8];
		end
		model[addr] = word;
	endfunction

	// called and left 1 ns after a rising edge
	task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic [STRB_W-1:0] strb, output logic [RESP_W-1:0] resp);
		awaddr = addr;
		awvalid = 1'b1;
		wdata = data;
		wstrb = strb;
		wvalid = 1'b1;
		bready = 1'b1;
		@(negedge clk);
		while (!(awready && wready))
			@(negedge clk);
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(negedge clk);
		while (!bvalid)
			@(negedge clk);
		resp = bresp;
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
		output logic [RESP_W-1:0] resp);
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b1;
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		@(negedge clk);
		while (!rvalid)
			@(negedge clk);
		data = rdata;
		resp = rresp;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic read_expect(input string name, input logic [ADDR_W-1:0] addr);
		logic [DATA_W-1:0] data;
		logic [RESP_W-1:0] resp;
		bus_read(addr, data, resp);
		check_value({name, " rdata"}, model[addr], data);
		check_value({name, " rresp"}, 32'(RESP_OKAY), 32'(resp));
	endtask

	task automatic test_sram_rw();
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [RESP_W-1:0] resp;
		int i;
		for (i = 0; i < 8; i++) begin
			addr = SRAM_BASE + ADDR_W'(4 * (3 * i + 1));
			data = $random(seed);
			bus_write(addr, data, 4'hF, resp);
			check_value("test_sram_rw bresp", 32'(RESP_OKAY), 32'(resp));
			note_write(addr, data, 4'hF);
		end
		for (i = 0; i < 8; i++)
			read_expect("test_sram_rw", SRAM_BASE + ADDR_W'(4 * (3 * i + 1)));
	endtask

	task automatic test_strobe();
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [RESP_W-1:0] resp;
		addr = SRAM_BASE + 32'h100;
		bus_write(addr, 32'h1122_3344, 4'hF, resp);
		note_write(addr, 32'h1122_3344, 4'hF);
		bus_write(addr, 32'hAABB_CCDD, 4'b0101, resp);
		check_value("test_strobe bresp", 32'(RESP_OKAY), 32'(resp));
		note_write(addr, 32'hAABB_CCDD, 4'b0101);
		bus_read(addr, data, resp);
		// bytes 0 and 2 new, bytes 1 and 3 kept
		check_value("test_strobe merge", 32'h11BB_33DD, data);
		check_value("test_strobe rresp", 32'(RESP_OKAY), 32'(resp));
		data = $random(seed);
		bus_write(addr, data, 4'b1000, resp);
		note_write(addr, data, 4'b1000);
		read_expect("test_strobe top byte", addr);
	endtask

	task automatic test_rtc_read();
		logic [DATA_W-1:0] first;
		logic [DATA_W-1:0] second;
		logic [DATA_W-1:0] high;
		logic [RESP_W-1:0] resp;
		bus_read(RTC_BASE, first, resp);
		check_value("test_rtc_read first rresp", 32'(RESP_OKAY), 32'(resp));
		repeat (40) @(posedge clk);
		#1;
		bus_read(RTC_BASE, second, resp);
		check_value("test_rtc_read second rresp", 32'(RESP_OKAY), 32'(resp));
		check_value("test_rtc_read increasing", 32'd1, 32'(second > first));
		// 40 idle cycles at 4 clocks per tick
		check_value("test_rtc_read tick count", 32'd1, 32'(second - first >= 32'd10));
		bus_read(RTC_BASE + 32'd4, high, resp);
		check_value("test_rtc_read high word", 32'd0, high);
		check_value("test_rtc_read high rresp", 32'(RESP_OKAY), 32'(resp));
	endtask

	task automatic test_errors();
		logic [DATA_W-1:0] data;
		logic [RESP_W-1:0] resp;
		bus_write(RTC_BASE, $random(seed), 4'hF, resp);
		check_value("test_errors rtc write", 32'(RESP_SLVERR), 32'(resp));
		read_expect("test_errors after slverr", SRAM_BASE + 32'h4);
		bus_read(UNMAPPED, data, resp);
		check_value("test_errors unmapped read", 32'(RESP_DECERR), 32'(resp));
		read_expect("test_errors after read decerr", SRAM_BASE + 32'h10);
		bus_write(UNMAPPED, $random(seed), 4'hF, resp);
		check_value("test_errors unmapped write", 32'(RESP_DECERR), 32'(resp));
		read_expect("test_errors after write decerr", SRAM_BASE + 32'h1C);
		// first word past the end of the sram
		bus_read(SRAM_BASE + ADDR_W'(4 * SRAM_WORDS), data, resp);
		check_value("test_errors sram end", 32'(RESP_DECERR), 32'(resp));
	endtask

	task automatic test_backpressure();
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [RESP_W-1:0] resp;
		addr = SRAM_BASE + 32'h200;
		data = $random(seed);
		bus_write(addr, data, 4'hF, resp);
		note_write(addr, data, 4'hF);
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b0;
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		repeat (10) begin
			@(negedge clk);
			check_value("test_backpressure rvalid", 32'd1, 32'(rvalid));
			check_value("test_backpressure rdata", model[addr], rdata);
		end
		@(posedge clk);
		#1;
		rready = 1'b1;
		@(negedge clk);
		check_value("test_backpressure final rvalid", 32'd1, 32'(rvalid));
		check_value("test_backpressure final rdata", model[addr], rdata);
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic test_read_priority();
		logic [ADDR_W-1:0] addr_r;
		logic [ADDR_W-1:0] addr_w;
		logic [DATA_W-1:0] new_w;
		logic [RESP_W-1:0] resp;
		addr_r = SRAM_BASE + 32'h300;
		addr_w = SRAM_BASE + 32'h304;
		new_w = $random(seed);
		bus_write(addr_r, 32'hCAFE_0001, 4'hF, resp);
		note_write(addr_r, 32'hCAFE_0001, 4'hF);
		bus_write(addr_w, 32'hCAFE_0002, 4'hF, resp);
		note_write(addr_w, 32'hCAFE_0002, 4'hF);
		// read and write presented together
		araddr = addr_r;
		arvalid = 1'b1;
		rready = 1'b1;
		awaddr = addr_w;
		awvalid = 1'b1;
		wdata = new_w;
		wstrb = 4'hF;
		wvalid = 1'b1;
		bready = 1'b1;
		@(negedge clk);
		while (!arready) begin
			// the write must not be taken ahead of the read
			check_value("test_read_priority early awready", 32'd0, 32'(awready));
			check_value("test_read_priority early wready", 32'd0, 32'(wready));
			@(negedge clk);
		end
		check_value("test_read_priority awready", 32'd0, 32'(awready));
		check_value("test_read_priority wready", 32'd0, 32'(wready));
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		@(negedge clk);
		while (!rvalid)
			@(negedge clk);
		check_value("test_read_priority rdata", 32'hCAFE_0001, rdata);
		check_value("test_read_priority rresp", 32'(RESP_OKAY), 32'(rresp));
		@(posedge clk);
		#1;
		rready = 1'b0;
		@(negedge clk);
		while (!(awready && wready))
			@(negedge clk);
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(negedge clk);
		while (!bvalid)
			@(negedge clk);
		check_value("test_read_priority bresp", 32'(RESP_OKAY), 32'(bresp));
		@(posedge clk);
		#1;
		bready = 1'b0;
		note_write(addr_w, new_w, 4'hF);
		read_expect("test_read_priority written word", addr_w);
		read_expect("test_read_priority read word", addr_r);
	endtask

	initial begin
		seed = 78;
		rst = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		check_value("reset arready", 32'd0, 32'(arready));
		check_value("reset awready", 32'd0, 32'(awready));
		check_value("reset wready", 32'd0, 32'(wready));
		check_value("reset rvalid", 32'd0, 32'(rvalid));
		check_value("reset bvalid", 32'd0, 32'(bvalid));
		test_sram_rw();
		test_strobe();
		test_rtc_read();
		test_errors();
		test_backpressure();
		test_read_priority();
		$display("NO ERRORS");
		$finish;
	end

endmodule

/* soc_top.sv */
module soc_top #(
	parameter int SRAM_WORDS = 256,
	parameter int RTC_DIV    = 4
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [soc_pkg::ADDR_W-1:0] araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [soc_pkg::DATA_W-1:0] rdata,
	output logic [soc_pkg::RESP_W-1:0] rresp,
	output logic                        rvalid,
	input  logic                        rready,
	input  logic [soc_pkg::ADDR_W-1:0] awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [soc_pkg::DATA_W-1:0] wdata,
	input  logic [soc_pkg::STRB_W-1:0] wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [soc_pkg::RESP_W-1:0] bresp,
	output logic                        bvalid,
	input  logic                        bready
);
	import soc_pkg::*;

	// crossbar to sram
	logic [ADDR_W-1:0] soc_araddr;
	logic              soc_arvalid;
	logic              soc_arready;
	logic [DATA_W-1:0] soc_rdata;
	logic [RESP_W-1:0] soc_rresp;
	logic              soc_rvalid;
	logic              soc_rready;
	logic [ADDR_W-1:0] soc_awaddr;
	logic              soc_awvalid;
	logic              soc_awready;
	logic [DATA_W-1:0] soc_wdata;
	logic [STRB_W-1:0] soc_wstrb;
	logic              soc_wvalid;
	logic              soc_wready;
	logic [RESP_W-1:0] soc_bresp;
	logic              soc_bvalid;
	logic              soc_bready;

	// crossbar to clock
	logic [ADDR_W-1:0] rtc_araddr;
	logic              rtc_arvalid;
	logic              rtc_arready;
	logic [DATA_W-1:0] rtc_rdata;
	logic [RESP_W-1:0] rtc_rresp;
	logic              rtc_rvalid;
	logic              rtc_rready;

	axi_xbar #(
		.SRAM_WORDS(SRAM_WORDS)
	) xbar_inst (
		.clk(clk), .rst(rst),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.soc_araddr(soc_araddr), .soc_arvalid(soc_arvalid), .soc_arready(soc_arready),
		.soc_rdata(soc_rdata), .soc_rresp(soc_rresp),
		.soc_rvalid(soc_rvalid), .soc_rready(soc_rready),
		.soc_awaddr(soc_awaddr), .soc_awvalid(soc_awvalid), .soc_awready(soc_awready),
		.soc_wdata(soc_wdata), .soc_wstrb(soc_wstrb),
		.soc_wvalid(soc_wvalid), .soc_wready(soc_wready),
		.soc_bresp(soc_bresp), .soc_bvalid(soc_bvalid), .soc_bready(soc_bready),
		.rtc_araddr(rtc_araddr), .rtc_arvalid(rtc_arvalid), .rtc_arready(rtc_arready),
		.rtc_rdata(rtc_rdata), .rtc_rresp(rtc_rresp),
		.rtc_rvalid(rtc_rvalid), .rtc_rready(rtc_rready)
	);

	sram_slave #(
		.SRAM_WORDS(SRAM_WORDS)
	) sram_inst (
		.clk(clk), .rst(rst),
		.araddr(soc_araddr), .arvalid(soc_arvalid), .arready(soc_arready),
		.rdata(soc_rdata), .rresp(soc_rresp), .rvalid(soc_rvalid), .rready(soc_rready),
		.awaddr(soc_awaddr), .awvalid(soc_awvalid), .awready(soc_awready),
		.wdata(soc_wdata), .wstrb(soc_wstrb), .wvalid(soc_wvalid), .wready(soc_wready),
		.bresp(soc_bresp), .bvalid(soc_bvalid), .bready(soc_bready)
	);

	rtc_slave #(
		.RTC_DIV(RTC_DIV)
	) rtc_inst (
		.clk(clk), .rst(rst),
		.araddr(rtc_araddr), .arvalid(rtc_arvalid), .arready(rtc_arready),
		.rdata(rtc_rdata), .rresp(rtc_rresp), .rvalid(rtc_rvalid), .rready(rtc_rready)
	);

endmodule

/* rtc_slave.sv */
module rtc_slave #(
	parameter int RTC_DIV = 4
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [soc_pkg::ADDR_W-1:0] araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [soc_pkg::DATA_W-1:0] rdata,
	output logic [soc_pkg::RESP_W-1:0] rresp,
	output logic                        rvalid,
	input  logic                        rready
);
	import soc_pkg::*;

	localparam int PRE_W = (RTC_DIV > 1) ? $clog2(RTC_DIV) : 1;

	logic [PRE_W-1:0]  pre_cnt;
	logic              pre_wrap;
	logic [63:0]       ticks;
	logic [ADDR_W-1:0] rd_off;
	logic              rd_fire;

	// prescaler, one tick every RTC_DIV clocks
	assign pre_wrap = (pre_cnt == PRE_W'(RTC_DIV - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			pre_cnt <= '0;
			ticks <= '0;
		end else if (pre_wrap) begin
			pre_cnt <= '0;
			ticks <= ticks + 64'd1;
		end else begin
			pre_cnt <= pre_cnt + PRE_W'(1);
		end
	end

	assign rd_off = araddr - RTC_BASE;
	assign arready = arvalid && !rvalid;
	assign rd_fire = arvalid && arready;
	assign rresp = RESP_OKAY;

	always_ff @(posedge clk) begin
		if (rst)
			rvalid <= 1'b0;
		else if (rd_fire)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	// offset 4 is the high word, anything else reads low
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			if (rd_off == ADDR_W'(4))
				rdata <= ticks[63:32];
			else
				rdata <= ticks[31:0];
		end
	end

endmodule

/* sram_slave.sv */
module sram_slave #(
	parameter int SRAM_WORDS = 256
) (
	input  logic                        clk,
	input  logic                        rst,
	// read channels
	input  logic [soc_pkg::ADDR_W-1:0] araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [soc_pkg::DATA_W-1:0] rdata,
	output logic [soc_pkg::RESP_W-1:0] rresp,
	output logic                        rvalid,
	input  logic                        rready,
	// write channels
	input  logic [soc_pkg::ADDR_W-1:0] awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [soc_pkg::DATA_W-1:0] wdata,
	input  logic [soc_pkg::STRB_W-1:0] wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [soc_pkg::RESP_W-1:0] bresp,
	output logic                        bvalid,
	input  logic                        bready
);
	import soc_pkg::*;

	localparam int IDX_W = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;

	logic [DATA_W-1:0] mem [SRAM_WORDS];
	logic [IDX_W-1:0]  rd_idx;
	logic [IDX_W-1:0]  wr_idx;
	logic              rd_fire;
	logic              wr_fire;

	// word index, wraps at the array size
	assign rd_idx = IDX_W'((araddr >> 2) % SRAM_WORDS);
	assign wr_idx = IDX_W'((awaddr >> 2) % SRAM_WORDS);

	// address taken as soon as it shows up, unless a response is pending
	assign arready = arvalid && !rvalid;
	assign rd_fire = arvalid && arready;

	// address and data go in together
	assign awready = awvalid && wvalid && !bvalid;
	assign wready = awready;
	assign wr_fire = awvalid && wvalid && awready;

	assign rresp = RESP_OKAY;
	assign bresp = RESP_OKAY;

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	// read data held until the response handshake
	always_ff @(posedge clk) begin
		if (rd_fire)
			rdata <= mem[rd_idx];
	end

	// byte lanes, only strobed bytes change
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (wstrb[b])
					mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
			end
		end
	end

	a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid)
		else $error("sram dropped rvalid before rready");

endmodule

/* axi_xbar.sv */
module axi_xbar #(
	parameter int SRAM_WORDS = 256
) (
	input  logic                        clk,
	input  logic                        rst,
	// master side
	input  logic [soc_pkg::ADDR_W-1:0] araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [soc_pkg::DATA_W-1:0] rdata,
	output logic [soc_pkg::RESP_W-1:0] rresp,
	output logic                        rvalid,
	input  logic                        rready,
	input  logic [soc_pkg::ADDR_W-1:0] awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [soc_pkg::DATA_W-1:0] wdata,
	input  logic [soc_pkg::STRB_W-1:0] wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [soc_pkg::RESP_W-1:0] bresp,
	output logic                        bvalid,
	input  logic                        bready,
	// sram side
	output logic [soc_pkg::ADDR_W-1:0] soc_araddr,
	output logic                        soc_arvalid,
	input  logic                        soc_arready,
	input  logic [soc_pkg::DATA_W-1:0] soc_rdata,
	input  logic [soc_pkg::RESP_W-1:0] soc_rresp,
	input  logic                        soc_rvalid,
	output logic                        soc_rready,
	output logic [soc_pkg::ADDR_W-1:0] soc_awaddr,
	output logic                        soc_awvalid,
	input  logic                        soc_awready,
	output logic [soc_pkg::DATA_W-1:0] soc_wdata,
	output logic [soc_pkg::STRB_W-1:0] soc_wstrb,
	output logic                        soc_wvalid,
	input  logic                        soc_wready,
	input  logic [soc_pkg::RESP_W-1:0] soc_bresp,
	input  logic                        soc_bvalid,
	output logic                        soc_bready,
	// rtc side, read only
	output logic [soc_pkg::ADDR_W-1:0] rtc_araddr,
	output logic                        rtc_arvalid,
	input  logic                        rtc_arready,
	input  logic [soc_pkg::DATA_W-1:0] rtc_rdata,
	input  logic [soc_pkg::RESP_W-1:0] rtc_rresp,
	input  logic                        rtc_rvalid,
	output logic                        rtc_rready
);
	import soc_pkg::*;

	localparam logic [1:0] IDLE       = 2'd0;
	localparam logic [1:0] HANDLE_SOC = 2'd1;
	localparam logic [1:0] HANDLE_RTC = 2'd2;
	localparam logic [1:0] LOCAL_ERR  = 2'd3;

	localparam logic [ADDR_W-1:0] SRAM_END = SRAM_BASE + ADDR_W'(4 * SRAM_WORDS);

	logic [1:0]        state;
	logic [1:0]        next_state;
	logic              is_write;
	logic              dec_write;
	logic [RESP_W-1:0] err_code;
	logic [RESP_W-1:0] dec_err;
	// local error path has taken the address, response is due
	logic              err_acc;

	function automatic logic in_sram(input logic [ADDR_W-1:0] addr);
		return (addr >= SRAM_BASE) && (addr < SRAM_END);
	endfunction

	function automatic logic in_rtc(input logic [ADDR_W-1:0] addr);
		return (addr >= RTC_BASE) && (addr < RTC_BASE + RTC_SIZE);
	endfunction

	// decode of the pending request, reads win
	always_comb begin
		next_state = state;
		dec_write = is_write;
		dec_err = err_code;
		case (state)
			IDLE: begin
				if (arvalid) begin
					dec_write = 1'b0;
					dec_err = RESP_DECERR;
					if (in_rtc(araddr))
						next_state = HANDLE_RTC;
					else if (in_sram(araddr))
						next_state = HANDLE_SOC;
					else
						next_state = LOCAL_ERR;
				end else if (awvalid && wvalid) begin
					dec_write = 1'b1;
					if (in_rtc(awaddr)) begin
						// clock is read only
						dec_err = RESP_SLVERR;
						next_state = LOCAL_ERR;
					end else if (in_sram(awaddr)) begin
						dec_err = RESP_DECERR;
						next_state = HANDLE_SOC;
					end else begin
						dec_err = RESP_DECERR;
						next_state = LOCAL_ERR;
					end
				end
			end
			HANDLE_SOC: begin
				if (is_write ? (soc_bvalid && bready) : (soc_rvalid && rready))
					next_state = IDLE;
			end
			HANDLE_RTC: begin
				if (rtc_rvalid && rready)
					next_state = IDLE;
			end
			default: begin
				if (err_acc && (is_write ? bready : rready))
					next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			is_write <= 1'b0;
			err_code <= RESP_OKAY;
			err_acc <= 1'b0;
		end else begin
			state <= next_state;
			is_write <= dec_write;
			err_code <= dec_err;
			err_acc <= (state == LOCAL_ERR);
		end
	end

	// routing, anything not selected stays at zero
	always_comb begin
		arready = 1'b0;
		rdata = '0;
		rresp = RESP_OKAY;
		rvalid = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		bresp = RESP_OKAY;
		bvalid = 1'b0;
		soc_araddr = '0;
		soc_arvalid = 1'b0;
		soc_rready = 1'b0;
		soc_awaddr = '0;
		soc_awvalid = 1'b0;
		soc_wdata = '0;
		soc_wstrb = '0;
		soc_wvalid = 1'b0;
		soc_bready = 1'b0;
		rtc_araddr = '0;
		rtc_arvalid = 1'b0;
		rtc_rready = 1'b0;
		case (state)
			HANDLE_SOC: begin
				if (is_write) begin
					soc_awaddr = awaddr;
					soc_awvalid = awvalid;
					awready = soc_awready;
					soc_wdata = wdata;
					soc_wstrb = wstrb;
					soc_wvalid = wvalid;
					wready = soc_wready;
					bresp = soc_bresp;
					bvalid = soc_bvalid;
					soc_bready = bready;
				end else begin
					soc_araddr = araddr;
					soc_arvalid = arvalid;
					arready = soc_arready;
					rdata = soc_rdata;
					rresp = soc_rresp;
					rvalid = soc_rvalid;
					soc_rready = rready;
				end
			end
			HANDLE_RTC: begin
				rtc_araddr = araddr;
				rtc_arvalid = arvalid;
				arready = rtc_arready;
				rdata = rtc_rdata;
				rresp = rtc_rresp;
				rvalid = rtc_rvalid;
				rtc_rready = rready;
			end
			LOCAL_ERR: begin
				// take the request first, answer the cycle after
				if (is_write) begin
					awready = !err_acc;
					wready = !err_acc;
					bvalid = err_acc;
					bresp = err_code;
				end else begin
					arready = !err_acc;
					rvalid = err_acc;
					rresp = err_code;
				end
			end
			default: begin
			end
		endcase
	end

	a_one_slave_read: assert property (@(posedge clk) disable iff (rst)
		!(soc_arvalid && rtc_arvalid))
		else $error("read request sent to both slaves");

	a_one_response: assert property (@(posedge clk) disable iff (rst)
		!(rvalid && bvalid))
		else $error("read and write responses at once");

endmodule

/* soc_pkg.sv */
package soc_pkg;

	// bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int RESP_W = 2;

	// response codes
	localparam logic [RESP_W-1:0] RESP_OKAY   = 2'd0;
	localparam logic [RESP_W-1:0] RESP_SLVERR = 2'd2;
	localparam logic [RESP_W-1:0] RESP_DECERR = 2'd3;

	// address map
	// sram size comes from the SRAM_WORDS parameter, not from here
	localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;

	// rtc region, low word at offset 0, high word at offset 4
	localparam logic [ADDR_W-1:0] RTC_BASE = 32'hA000_0048;
	localparam logic [ADDR_W-1:0] RTC_SIZE = 32'd8;

endpackage
